/* Makefile */
# Verilator build and run of the performance counter testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = perfCounterTb
FILELIST  = tb.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
RUN_FLAGS = +verilator+error+limit+1000
FAIL_MSG  = Something failed
PASS_MSG  = Everything OK

SOURCES = $(wildcard rtl/*.sv rtl/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/commitEventCounter.sv */
//--------------------------------------------------------------------------
// Cycle, commit and refetch counters. One cycle from strobe to register,
// all counters clear on a synchronous reset and wrap on overflow.
//--------------------------------------------------------------------------

`include "perfCounter_settings.svh"

module commitEventCounter
    import perfCounterPkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  commitNum_t   commitNum,
    input  logic         refetchThisPC,
    input  logic         refetchNextPC,
    input  logic         refetchBrTarget,
    output counterData_t cycleCount,
    output counterData_t commitCount,
    output counterData_t refetchThisPCCount,
    output counterData_t refetchNextPCCount,
    output counterData_t refetchBrTargetCount
);

    // cycles since the last reset edge
    always_ff @(posedge clk) begin
        if (rst) begin
            cycleCount <= '0;
        end else begin
            cycleCount <= cycleCount + counterData_t'(1);
        end
    end

    // committed instructions, zero-extended commit count per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            commitCount <= '0;
        end else begin
            commitCount <= commitCount + counterData_t'(commitNum);
        end
    end

    // refetch kinds, each counter only follows its own strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            refetchThisPCCount   <= '0;
            refetchNextPCCount   <= '0;
            refetchBrTargetCount <= '0;
        end else begin
            refetchThisPCCount <=
                refetchThisPCCount + counterData_t'(refetchThisPC);
            refetchNextPCCount <=
                refetchNextPCCount + counterData_t'(refetchNextPC);
            refetchBrTargetCount <=
                refetchBrTargetCount + counterData_t'(refetchBrTarget);
        end
    end

endmodule

/* rtl/counterReadSelect.sv */
//--------------------------------------------------------------------------
// Combinational read mux, one per port. Free codes 6 and 7 give zero.
//--------------------------------------------------------------------------

`include "perfCounter_settings.svh"

module counterReadSelect
    import perfCounterPkg::*;
(
    input  counterSel_t  counterSel [`PERF_READ_PORTS],
    input  counterData_t cycleCount,
    input  counterData_t commitCount,
    input  counterData_t refetchThisPCCount,
    input  counterData_t refetchNextPCCount,
    input  counterData_t refetchBrTargetCount,
    input  counterData_t loadMissCount,
    output counterData_t counterData [`PERF_READ_PORTS]
);

    // ports are independent, any two may pick the same counter
    always_comb begin
        for (int i = 0; i < `PERF_READ_PORTS; i++) begin
            case (counterSel[i])
                CNT_SEL_CYCLE: begin
                    counterData[i] = cycleCount;
                end
                CNT_SEL_COMMIT: begin
                    counterData[i] = commitCount;
                end
                CNT_SEL_REFETCH_THIS_PC: begin
                    counterData[i] = refetchThisPCCount;
                end
                CNT_SEL_REFETCH_NEXT_PC: begin
                    counterData[i] = refetchNextPCCount;
                end
                CNT_SEL_REFETCH_BR_TARGET: begin
                    counterData[i] = refetchBrTargetCount;
                end
                CNT_SEL_LOAD_MISS: begin
                    counterData[i] = loadMissCount;
                end
                // unused codes
                default: begin
                    counterData[i] = '0;
                end
            endcase
        end
    end

endmodule

/* rtl/loadMissCounter.sv */
//--------------------------------------------------------------------------
// Running count of load misses over all memory lanes. Adds the number
// of set lanes each cycle, so it may rise by up to PERF_MEM_ISSUE_WIDTH.
//--------------------------------------------------------------------------

`include "perfCounter_settings.svh"

module loadMissCounter
    import perfCounterPkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  loadMissVec_t loadMiss,
    output counterData_t loadMissCount
);

    // wide enough for every lane set at once
    localparam int LaneCountWidth = $clog2(`PERF_MEM_ISSUE_WIDTH + 1);

    logic [LaneCountWidth-1:0] missLanes;

    // population count of the strobes
    always_comb begin
        missLanes = '0;
        for (int i = 0; i < `PERF_MEM_ISSUE_WIDTH; i++) begin
            missLanes = missLanes + LaneCountWidth'(loadMiss[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            loadMissCount <= '0;
        end else begin
            loadMissCount <= loadMissCount + counterData_t'(missLanes);
        end
    end

endmodule

/* rtl/perfCounterPkg.sv */
//--------------------------------------------------------------------------
// Types shared by the performance counter unit. Select codes 6 and 7
// are not part of the enum and read as zero on any port.
//--------------------------------------------------------------------------

`include "perfCounter_settings.svh"

package perfCounterPkg;

    // one counter value, also the read data of a port
    typedef logic [`PERF_COUNTER_WIDTH-1:0] counterData_t;

    // instructions committed in one cycle, 0 up to PERF_COMMIT_WIDTH
    typedef logic [$clog2(`PERF_COMMIT_WIDTH + 1)-1:0] commitNum_t;

    // one load-miss strobe per memory lane
    typedef logic [`PERF_MEM_ISSUE_WIDTH-1:0] loadMissVec_t;

    // counter select code of a read port
    typedef enum logic [2:0] {
        CNT_SEL_CYCLE             = 3'd0,
        CNT_SEL_COMMIT            = 3'd1,
        CNT_SEL_REFETCH_THIS_PC   = 3'd2,
        CNT_SEL_REFETCH_NEXT_PC   = 3'd3,
        CNT_SEL_REFETCH_BR_TARGET = 3'd4,
        CNT_SEL_LOAD_MISS         = 3'd5
        // 6 and 7 left free, they read zero
    } counterSel_t;

endpackage

/* rtl/perfCounterTop.sv */
//--------------------------------------------------------------------------
// Performance counter unit. Strobes count in the cycle they are high with
// no back-pressure; read data follows counterSel in the same cycle.
//--------------------------------------------------------------------------

`include "perfCounter_settings.svh"

module perfCounterTop
    import perfCounterPkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  commitNum_t   commitNum,
    input  logic         refetchThisPC,
    input  logic         refetchNextPC,
    input  logic         refetchBrTarget,
    input  loadMissVec_t loadMiss,
    input  counterSel_t  counterSel [`PERF_READ_PORTS],
    output counterData_t counterData [`PERF_READ_PORTS]
);

    counterData_t cycleCount;
    counterData_t commitCount;
    counterData_t refetchThisPCCount;
    counterData_t refetchNextPCCount;
    counterData_t refetchBrTargetCount;
    counterData_t loadMissCount;

    commitEventCounter commitEvents (
        .clk                 (clk),
        .rst                 (rst),
        .commitNum           (commitNum),
        .refetchThisPC       (refetchThisPC),
        .refetchNextPC       (refetchNextPC),
        .refetchBrTarget     (refetchBrTarget),
        .cycleCount          (cycleCount),
        .commitCount         (commitCount),
        .refetchThisPCCount  (refetchThisPCCount),
        .refetchNextPCCount  (refetchNextPCCount),
        .refetchBrTargetCount(refetchBrTargetCount)
    );

    loadMissCounter loadMisses (
        .clk          (clk),
        .rst          (rst),
        .loadMiss     (loadMiss),
        .loadMissCount(loadMissCount)
    );

    // both counting parts feed every read port
    counterReadSelect readSelect (
        .counterSel          (counterSel),
        .cycleCount          (cycleCount),
        .commitCount         (commitCount),
        .refetchThisPCCount  (refetchThisPCCount),
        .refetchNextPCCount  (refetchNextPCCount),
        .refetchBrTargetCount(refetchBrTargetCount),
        .loadMissCount       (loadMissCount),
        .counterData         (counterData)
    );

endmodule

/* rtl/perfCounter_settings.svh */
//--------------------------------------------------------------------------
// Widths of the performance counter unit. Counters wrap modulo
// 2^PERF_COUNTER_WIDTH. Commit count must fit 0..PERF_COMMIT_WIDTH.
//--------------------------------------------------------------------------

`ifndef PERF_COUNTER_SETTINGS_SVH
`define PERF_COUNTER_SETTINGS_SVH

// width of every counter and of the read data
`define PERF_COUNTER_WIDTH 32

// most instructions committed in one cycle
`define PERF_COMMIT_WIDTH 4

// memory issue lanes, one load-miss strobe each
`define PERF_MEM_ISSUE_WIDTH 2

// independent read ports
`define PERF_READ_PORTS 2

`endif

/* tb.f */
+incdir+rtl
rtl/perfCounterPkg.sv
rtl/commitEventCounter.sv
rtl/loadMissCounter.sv
rtl/counterReadSelect.sv
rtl/perfCounterTop.sv
test/perfCounter_chk.sv
test/perfCounterTb.sv

/* test/perfCounterTb.sv */
//--------------------------------------------------------------------------
// Testbench for perfCounterTop with two read ports. Directed table first,
// then random traffic against a reference model with a reset pulse.
//--------------------------------------------------------------------------

`include "perfCounter_settings.svh"

module perfCounterTb
    import perfCounterPkg::*;
();

    localparam int NumRows      = 10;
    localparam int RandomCycles = 300;
    localparam int ResetTimeout = 8;

    // one directed step and the two reads one cycle after its strobes
    typedef struct packed {
        commitNum_t   commitNum;
        logic         thisPC;
        logic         nextPC;
        logic         brTarget;
        loadMissVec_t loadMiss;
        logic [2:0]   sel0;
        logic [2:0]   sel1;
        counterData_t want0;
        counterData_t want1;
    } tableRow_t;

    logic         clk;
    logic         rst;
    commitNum_t   commitNum;
    logic         refetchThisPC;
    logic         refetchNextPC;
    logic         refetchBrTarget;
    loadMissVec_t loadMiss;
    counterSel_t  counterSel [`PERF_READ_PORTS];
    counterData_t counterData [`PERF_READ_PORTS];

    tableRow_t    dirTable [NumRows];
    integer       seed;
    int           checks;
    int           valueErrors;
    int           timeoutErrors;

    // reference model state after the next rising edge
    counterData_t refCycle;
    counterData_t refCommit;
    counterData_t refThisPC;
    counterData_t refNextPC;
    counterData_t refBrTarget;
    counterData_t refLoadMiss;

    perfCounterTop dut (
        .clk            (clk),
        .rst            (rst),
        .commitNum      (commitNum),
        .refetchThisPC  (refetchThisPC),
        .refetchNextPC  (refetchNextPC),
        .refetchBrTarget(refetchBrTarget),
        .loadMiss       (loadMiss),
        .counterSel     (counterSel),
        .counterData    (counterData)
    );

    always #50 clk = ~clk;

    task automatic checkCounter(input string portName, input counterSel_t sel,
                                input counterData_t expected, input counterData_t actual);
        checks++;
        if (actual !== expected) begin
            valueErrors++;
            $display("[FAIL] t=%0t %s (sel %0d) expected %0d, got %0d",
                     $time, portName, sel, expected, actual);
        end
    endtask

    task automatic checkPorts(input counterData_t want0, input counterData_t want1);
        checkCounter("counterData[0]", counterSel[0], want0, counterData[0]);
        checkCounter("counterData[1]", counterSel[1], want1, counterData[1]);
    endtask

    // what a port should show for a select code
    function automatic counterData_t expectedRead(input counterSel_t sel);
        case (sel)
            CNT_SEL_CYCLE:             expectedRead = refCycle;
            CNT_SEL_COMMIT:            expectedRead = refCommit;
            CNT_SEL_REFETCH_THIS_PC:   expectedRead = refThisPC;
            CNT_SEL_REFETCH_NEXT_PC:   expectedRead = refNextPC;
            CNT_SEL_REFETCH_BR_TARGET: expectedRead = refBrTarget;
            CNT_SEL_LOAD_MISS:         expectedRead = refLoadMiss;
            default:                   expectedRead = '0;
        endcase
    endfunction

    task automatic updateModel(input logic rstIn, input commitNum_t cn, input logic thisPC,
                               input logic nextPC, input logic brTarget, input loadMissVec_t lm);
        if (rstIn) begin
            refCycle    = '0;
            refCommit   = '0;
            refThisPC   = '0;
            refNextPC   = '0;
            refBrTarget = '0;
            refLoadMiss = '0;
        end else begin
            refCycle    = refCycle + counterData_t'(1);
            refCommit   = refCommit + counterData_t'(cn);
            refThisPC   = refThisPC + counterData_t'(thisPC);
            refNextPC   = refNextPC + counterData_t'(nextPC);
            refBrTarget = refBrTarget + counterData_t'(brTarget);
            // every set lane is one miss
            refLoadMiss = refLoadMiss + counterData_t'($countones(lm));
        end
    endtask

    // called right after a falling edge
    task automatic driveInputs(input logic rstIn, input commitNum_t cn, input logic thisPC,
                               input logic nextPC, input logic brTarget, input loadMissVec_t lm,
                               input counterSel_t sel0, input counterSel_t sel1);
        rst             = rstIn;
        commitNum       = cn;
        refetchThisPC   = thisPC;
        refetchNextPC   = nextPC;
        refetchBrTarget = brTarget;
        loadMiss        = lm;
        counterSel[0]   = sel0;
        counterSel[1]   = sel1;
        updateModel(rstIn, cn, thisPC, nextPC, brTarget, lm);
    endtask

    // want values are the selected running totals after each row
    task automatic fillTable();
        dirTable[0] = '{3'd2, 1'b0, 1'b0, 1'b0, 2'b00, 3'd0, 3'd1, 32'd1, 32'd2};
        dirTable[1] = '{3'd0, 1'b1, 1'b0, 1'b0, 2'b01, 3'd2, 3'd5, 32'd1, 32'd1};
        dirTable[2] = '{3'd4, 1'b0, 1'b1, 1'b0, 2'b11, 3'd1, 3'd5, 32'd6, 32'd3};
        dirTable[3] = '{3'd1, 1'b0, 1'b0, 1'b1, 2'b10, 3'd4, 3'd3, 32'd1, 32'd1};
        dirTable[4] = '{3'd3, 1'b1, 1'b1, 1'b1, 2'b00, 3'd2, 3'd3, 32'd2, 32'd2};
        dirTable[5] = '{3'd4, 1'b1, 1'b1, 1'b1, 2'b11, 3'd4, 3'd0, 32'd3, 32'd6};
        dirTable[6] = '{3'd0, 1'b0, 1'b0, 1'b0, 2'b00, 3'd6, 3'd7, 32'd0, 32'd0};
        dirTable[7] = '{3'd0, 1'b0, 1'b0, 1'b0, 2'b00, 3'd7, 3'd5, 32'd0, 32'd6};
        dirTable[8] = '{3'd4, 1'b0, 1'b0, 1'b0, 2'b00, 3'd1, 3'd0, 32'd18, 32'd9};
        dirTable[9] = '{3'd0, 1'b1, 1'b0, 1'b0, 2'b01, 3'd5, 3'd2, 32'd7, 32'd4};
    endtask

    initial begin
        int          held;
        logic [31:0] word;
        logic        rstNow;
        seed          = 32'hf809_79b5;
        checks        = 0;
        valueErrors   = 0;
        timeoutErrors = 0;
        clk           = 1'b0;
        fillTable();
        driveInputs(1'b1, '0, 1'b0, 1'b0, 1'b0, '0, CNT_SEL_CYCLE, CNT_SEL_CYCLE);

        // hold reset until the cycle counter reads zero
        held = 0;
        do begin
            @(negedge clk);
            held++;
        end while (counterData[0] !== '0 && held < ResetTimeout);
        if (counterData[0] !== '0) begin
            timeoutErrors++;
            $display("timeout: reset did not clear the cycle counter in %0d cycles", held);
        end

        // all eight codes read zero for the rest of the reset
        for (int code = 0; code < 4; code++) begin
            driveInputs(1'b1, '0, 1'b0, 1'b0, 1'b0, '0,
                        counterSel_t'(3'(code)), counterSel_t'(3'(code + 4)));
            @(negedge clk);
            checkPorts('0, '0);
        end

        for (int r = 0; r < NumRows; r++) begin
            driveInputs(1'b0, dirTable[r].commitNum, dirTable[r].thisPC, dirTable[r].nextPC,
                        dirTable[r].brTarget, dirTable[r].loadMiss,
                        counterSel_t'(dirTable[r].sel0), counterSel_t'(dirTable[r].sel1));
            @(negedge clk);
            checkPorts(dirTable[r].want0, dirTable[r].want1);
        end

        // random traffic with two reset cycles in the middle
        for (int c = 0; c < RandomCycles; c++) begin
            word   = $random(seed);
            rstNow = (c >= 150 && c < 152);
            driveInputs(rstNow, commitNum_t'(word[7:0] % 8'd5), word[8], word[9], word[10],
                        loadMissVec_t'(word[12:11]),
                        counterSel_t'(word[19:17]), counterSel_t'(word[22:20]));
            @(negedge clk);
            checkPorts(expectedRead(counterSel[0]), expectedRead(counterSel[1]));
        end

        $display("checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
                 checks, valueErrors, timeoutErrors, dut.chk.failCount);
        if (valueErrors + timeoutErrors + dut.chk.failCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* test/perfCounter_chk.sv */
//--------------------------------------------------------------------------
// Concurrent checks bound into perfCounterTop. Relies on the internal
// loadMissCount signal of the top level.
//--------------------------------------------------------------------------

`include "perfCounter_settings.svh"

module perfCounter_chk
    import perfCounterPkg::*;
(
    input logic         clk,
    input logic         rst,
    input commitNum_t   commitNum,
    input counterSel_t  counterSel [`PERF_READ_PORTS],
    input counterData_t counterData [`PERF_READ_PORTS],
    input counterData_t loadMissCount
);

    // failed assertions so far
    int failCount = 0;

    commitNumInRange: assert property (@(posedge clk)
        commitNum <= commitNum_t'(`PERF_COMMIT_WIDTH))
    else begin
        failCount++;
        $error("commit count %0d above the commit width", commitNum);
    end

    // wrap-safe difference of two samples
    loadMissStep: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |->
            loadMissCount - $past(loadMissCount) <= counterData_t'(`PERF_MEM_ISSUE_WIDTH))
    else begin
        failCount++;
        $error("load-miss count rose by more than the lane count");
    end

    for (genvar p = 0; p < `PERF_READ_PORTS; p++) begin : gPort
        cycleStep: assert property (@(posedge clk) disable iff (rst)
            (counterSel[p] == CNT_SEL_CYCLE && $past(counterSel[p]) == CNT_SEL_CYCLE
                && !$past(rst)) |->
                counterData[p] == $past(counterData[p]) + counterData_t'(1))
        else begin
            failCount++;
            $error("cycle count on port %0d did not rise by one", p);
        end

        freeCodeZero: assert property (@(posedge clk)
            3'(counterSel[p]) >= 3'd6 |-> counterData[p] == '0)
        else begin
            failCount++;
            $error("free select code on port %0d read non-zero", p);
        end
    end

endmodule

bind perfCounterTop perfCounter_chk chk (
    .clk          (clk),
    .rst          (rst),
    .commitNum    (commitNum),
    .counterSel   (counterSel),
    .counterData  (counterData),
    .loadMissCount(loadMissCount)
);
